/* common/matcalc_pkg.sv */
package matcalc_pkg;

    // ==================================================
    // widths and table sizes
    // ==================================================
    localparam int DIM_W      = 8;
    localparam int ADDR_W     = 8;
    localparam int LED_W      = 8;
    localparam int MAX_TYPES  = 4;
    localparam int TYPE_IDX_W = 2;
    localparam int MAX_COPIES = 2;
    // valid count per entry, 0..MAX_COPIES
    localparam int CNT_W      = 2;
    localparam int TYPES_W    = 3;
    localparam int TOTAL_W    = 4;

    // ==================================================
    // sequencer states and codes
    // ==================================================
    typedef enum logic [4:0] {
        IDLE,
        INPUT,
        CALC_SELECT_OP,
        CALC_GET_DIM,
        CALC_FILTER,
        CALC_GET_ID,
        CALC_EXECUTE,
        WAIT_DECISION,
        ERROR
    } state_t;

    // unlisted codes run as add
    typedef enum logic [2:0] {
        OP_TRANSPOSE = 3'b000,
        OP_ADD       = 3'b001,
        OP_MATMUL    = 3'b011
    } op_t;

    typedef enum logic [1:0] {
        TASK_STORE = 2'd0,
        TASK_DIMS  = 2'd1,
        TASK_ID    = 2'd2
    } task_t;

    // one pattern per state group
    localparam logic [LED_W-1:0] LED_IDLE  = 8'h01;
    localparam logic [LED_W-1:0] LED_INPUT = 8'h02;
    localparam logic [LED_W-1:0] LED_CALC  = 8'h08;
    localparam logic [LED_W-1:0] LED_WAIT  = 8'h80;
    localparam logic [LED_W-1:0] LED_ERROR = 8'hFF;

endpackage

/* common/table_if.sv */
`timescale 1ns/1ns

interface table_if;
    import matcalc_pkg::*;

    // request side
    logic [DIM_W-1:0]      lookup_m;
    logic [DIM_W-1:0]      lookup_n;
    logic                  store_req;
    logic                  filter_req;
    logic [DIM_W-1:0]      id_val;

    // answer side, combinational in the table
    logic                  hit;
    logic [TYPE_IDX_W-1:0] hit_idx;
    logic [CNT_W-1:0]      hit_count;
    logic [ADDR_W-1:0]     next_addr;
    logic [ADDR_W-1:0]     id_addr;
    logic [TYPES_W-1:0]    types_count;
    logic [TOTAL_W-1:0]    total_count;

    modport seq (
        output lookup_m, lookup_n, store_req, filter_req, id_val,
        input  hit, hit_idx, hit_count, next_addr, id_addr,
        input  types_count, total_count
    );

    modport tbl (
        input  lookup_m, lookup_n, store_req, filter_req, id_val,
        output hit, hit_idx, hit_count, next_addr, id_addr,
        output types_count, total_count
    );

endinterface

/* hdl/btn_edge.sv */
`timescale 1ns/1ns

module btn_edge (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] i_btn,
    output logic       o_confirm,
    output logic       o_retry,
    output logic       o_menu
);

    logic [2:0] btn_s1;
    logic [2:0] btn_s2;
    logic [2:0] pulse_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btn_s1  <= '0;
            btn_s2  <= '0;
            pulse_q <= '0;
        end else begin
            btn_s1  <= i_btn;
            btn_s2  <= btn_s1;
            // rising edge, registered
            pulse_q <= btn_s1 & ~btn_s2;
        end
    end

    assign o_confirm = pulse_q[0];
    assign o_retry   = pulse_q[1];
    assign o_menu    = pulse_q[2];

    a_pulse_single: assert property (@(posedge clk) disable iff (!rst_n)
        !(|(pulse_q & $past(pulse_q))));

endmodule

/* mmu/matrix_table.sv */
`timescale 1ns/1ns

module matrix_table (
    input  logic clk,
    input  logic rst_n,
    table_if.tbl tb
);
    import matcalc_pkg::*;

    // entry payload
    logic [DIM_W-1:0]   ent_m     [MAX_TYPES];
    logic [DIM_W-1:0]   ent_n     [MAX_TYPES];
    logic [ADDR_W-1:0]  ent_start [MAX_TYPES];
    // entry control
    logic               ent_slot  [MAX_TYPES];
    logic [CNT_W-1:0]   ent_cnt   [MAX_TYPES];
    logic [TYPES_W-1:0] ent_used;
    logic [ADDR_W-1:0]  free_ptr;

    logic [ADDR_W-1:0]  mat_size;
    logic               new_ok;

    // ==================================================
    // search and address arithmetic
    // ==================================================
    assign mat_size = ADDR_W'(tb.lookup_m * tb.lookup_n);

    always_comb begin
        tb.hit     = 1'b0;
        tb.hit_idx = '0;
        for (int i = 0; i < MAX_TYPES; i++) begin
            if (i < ent_used && ent_m[i] == tb.lookup_m && ent_n[i] == tb.lookup_n
                && (!tb.filter_req || ent_cnt[i] != '0)) begin
                tb.hit     = 1'b1;
                tb.hit_idx = TYPE_IDX_W'(i);
            end
        end
    end

    assign tb.hit_count = tb.hit ? ent_cnt[tb.hit_idx] : '0;

    // stored shape alternates between its two slots
    assign tb.next_addr = tb.hit
        ? ent_start[tb.hit_idx] + (ent_slot[tb.hit_idx] ? mat_size : '0)
        : free_ptr;

    assign tb.id_addr = ent_start[tb.hit_idx]
        + ADDR_W'((tb.id_val - DIM_W'(1)) * mat_size);

    always_comb begin
        tb.total_count = '0;
        for (int i = 0; i < MAX_TYPES; i++) begin
            tb.total_count = tb.total_count + TOTAL_W'(ent_cnt[i]);
        end
    end

    assign tb.types_count = ent_used;

    // ==================================================
    // store rule
    // ==================================================
    assign new_ok = tb.store_req && !tb.hit && (ent_used < TYPES_W'(MAX_TYPES));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_used <= '0;
            free_ptr <= '0;
            for (int i = 0; i < MAX_TYPES; i++) begin
                ent_slot[i] <= 1'b0;
                ent_cnt[i]  <= '0;
            end
        end else if (tb.store_req && tb.hit) begin
            ent_slot[tb.hit_idx] <= ~ent_slot[tb.hit_idx];
            if (ent_cnt[tb.hit_idx] < CNT_W'(MAX_COPIES)) begin
                ent_cnt[tb.hit_idx] <= ent_cnt[tb.hit_idx] + 1'b1;
            end
        end else if (new_ok) begin
            ent_slot[ent_used[TYPE_IDX_W-1:0]] <= 1'b1;
            ent_cnt[ent_used[TYPE_IDX_W-1:0]]  <= CNT_W'(1);
            // two slots reserved per shape
            free_ptr <= free_ptr + {mat_size[ADDR_W-2:0], 1'b0};
            ent_used <= ent_used + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (new_ok) begin
            ent_m[ent_used[TYPE_IDX_W-1:0]]     <= tb.lookup_m;
            ent_n[ent_used[TYPE_IDX_W-1:0]]     <= tb.lookup_n;
            ent_start[ent_used[TYPE_IDX_W-1:0]] <= free_ptr;
        end
    end

    for (genvar g = 0; g < MAX_TYPES; g++) begin : g_cnt_chk
        a_cnt_limit: assert property (@(posedge clk) disable iff (!rst_n)
            ent_cnt[g] <= CNT_W'(MAX_COPIES));
    end

    a_store_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        tb.store_req |=> !tb.store_req);

endmodule

/* ctrl/calc_sequencer.sv */
`timescale 1ns/1ns

module calc_sequencer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              i_confirm,
    input  logic                              i_retry,
    input  logic                              i_menu,
    input  logic [7:0]                        i_sw,
    input  logic                              i_dims_valid,
    input  logic [matcalc_pkg::DIM_W-1:0]     i_dim_m,
    input  logic [matcalc_pkg::DIM_W-1:0]     i_dim_n,
    input  logic                              i_rx_done,
    input  logic                              i_timeout,
    input  logic                              i_id_valid,
    input  logic [matcalc_pkg::DIM_W-1:0]     i_id_val,
    input  logic                              i_calc_done,
    table_if.seq                              tb,
    output logic                              o_en_input,
    output matcalc_pkg::task_t                o_task_mode,
    output logic                              o_addr_ready,
    output logic [matcalc_pkg::ADDR_W-1:0]    o_base_addr,
    output logic                              o_start_calc,
    output matcalc_pkg::op_t                  o_op_code,
    output logic [matcalc_pkg::ADDR_W-1:0]    o_op1_addr,
    output logic [matcalc_pkg::ADDR_W-1:0]    o_op2_addr,
    output logic [matcalc_pkg::DIM_W-1:0]     o_op1_m,
    output logic [matcalc_pkg::DIM_W-1:0]     o_op1_n,
    output logic [matcalc_pkg::DIM_W-1:0]     o_op2_m,
    output logic [matcalc_pkg::DIM_W-1:0]     o_op2_n,
    output logic [matcalc_pkg::ADDR_W-1:0]    o_res_addr,
    output matcalc_pkg::state_t               o_state,
    output logic                              o_logic_error,
    output logic [matcalc_pkg::LED_W-1:0]     o_led
);
    import matcalc_pkg::*;

    state_t           state;
    state_t           next_state;
    state_t           r_mode;
    logic             r_stage;
    logic             dims_q;
    logic [DIM_W-1:0] r_dim_m;
    logic [DIM_W-1:0] r_dim_n;
    logic [DIM_W-1:0] res_m;
    logic [DIM_W-1:0] res_n;
    logic [LED_W-1:0] led_next;
    logic             input_wait;
    logic             id_ok;

    assign input_wait = (state == INPUT) || (state == CALC_GET_DIM) || (state == CALC_GET_ID);
    assign id_ok      = (i_id_val != '0) && (i_id_val <= DIM_W'(tb.hit_count));
    assign o_en_input = input_wait;
    assign o_state    = state;

    always_comb begin
        case (state)
            CALC_GET_DIM: o_task_mode = TASK_DIMS;
            CALC_GET_ID:  o_task_mode = TASK_ID;
            default:      o_task_mode = TASK_STORE;
        endcase
    end

    // result shape of the latched operation
    always_comb begin
        res_m = o_op1_m;
        res_n = o_op1_n;
        case (o_op_code)
            OP_TRANSPOSE: begin
                res_m = o_op1_n;
                res_n = o_op1_m;
            end
            OP_MATMUL: res_n = o_op2_n;
            default: ;
        endcase
    end

    // ==================================================
    // table requests
    // ==================================================
    always_comb begin
        tb.lookup_m = r_dim_m;
        tb.lookup_n = r_dim_n;
        if (state == INPUT) begin
            tb.lookup_m = i_dim_m;
            tb.lookup_n = i_dim_n;
        end else if (state == CALC_EXECUTE) begin
            tb.lookup_m = res_m;
            tb.lookup_n = res_n;
        end
    end

    assign tb.filter_req = (state == CALC_FILTER) || (state == CALC_GET_ID);
    assign tb.id_val     = i_id_val;
    assign tb.store_req  = !i_menu
        && (((state == INPUT) && i_dims_valid && !dims_q)
            || ((state == CALC_EXECUTE) && i_calc_done));

    // ==================================================
    // next state
    // ==================================================
    always_comb begin
        next_state = state;
        if (i_menu) begin
            next_state = IDLE;
        end else if (input_wait && i_timeout) begin
            next_state = ERROR;
        end else begin
            case (state)
                IDLE: begin
                    // sw 11 is not a mode
                    if (i_confirm && !(i_sw[1] && i_sw[0]))
                        next_state = i_sw[1] ? CALC_SELECT_OP : INPUT;
                end
                INPUT:          if (i_rx_done) next_state = WAIT_DECISION;
                CALC_SELECT_OP: if (i_confirm) next_state = CALC_GET_DIM;
                CALC_GET_DIM:   if (i_dims_valid) next_state = CALC_FILTER;
                CALC_FILTER:    next_state = tb.hit ? CALC_GET_ID : CALC_GET_DIM;
                CALC_GET_ID: begin
                    if (i_id_valid && id_ok) begin
                        if (!r_stage && o_op_code != OP_TRANSPOSE)
                            next_state = CALC_GET_DIM;
                        else
                            next_state = CALC_EXECUTE;
                    end
                end
                CALC_EXECUTE:   if (i_calc_done) next_state = WAIT_DECISION;
                WAIT_DECISION: begin
                    if (i_confirm)
                        next_state = IDLE;
                    else if (i_retry)
                        next_state = r_mode;
                end
                ERROR:          if (i_confirm) next_state = IDLE;
                default:        next_state = IDLE;
            endcase
        end
    end

    always_comb begin
        case (next_state)
            IDLE:          led_next = LED_IDLE;
            INPUT:         led_next = LED_INPUT;
            WAIT_DECISION: led_next = LED_WAIT;
            ERROR:         led_next = LED_ERROR;
            default:       led_next = LED_CALC;
        endcase
    end

    // ==================================================
    // control registers
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            r_mode        <= IDLE;
            r_stage       <= 1'b0;
            dims_q        <= 1'b0;
            o_addr_ready  <= 1'b0;
            o_start_calc  <= 1'b0;
            o_logic_error <= 1'b0;
            o_led         <= '0;
        end else begin
            state        <= next_state;
            dims_q       <= i_dims_valid;
            o_led        <= led_next;
            o_addr_ready <= (state == INPUT) && i_dims_valid;
            o_start_calc <= (state == CALC_EXECUTE) && !i_calc_done && !i_menu;
            case (state)
                IDLE: begin
                    o_logic_error <= 1'b0;
                    if (next_state != IDLE)
                        r_mode <= next_state;
                end
                CALC_SELECT_OP: begin
                    r_stage       <= 1'b0;
                    o_logic_error <= 1'b0;
                end
                CALC_GET_DIM: if (i_dims_valid) o_logic_error <= 1'b0;
                CALC_FILTER:  o_logic_error <= !tb.hit;
                CALC_GET_ID: begin
                    if (i_id_valid) begin
                        o_logic_error <= !id_ok;
                        if (id_ok)
                            r_stage <= 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // ==================================================
    // operand context
    // ==================================================
    always_ff @(posedge clk) begin
        if (state == INPUT && i_dims_valid && !dims_q)
            o_base_addr <= tb.next_addr;
        if (state == CALC_GET_DIM && i_dims_valid) begin
            r_dim_m <= i_dim_m;
            r_dim_n <= i_dim_n;
        end
        if (state == CALC_SELECT_OP && i_confirm) begin
            case (i_sw[7:5])
                OP_TRANSPOSE: o_op_code <= OP_TRANSPOSE;
                OP_MATMUL:    o_op_code <= OP_MATMUL;
                default:      o_op_code <= OP_ADD;
            endcase
        end
        if (state == CALC_GET_ID && i_id_valid && id_ok) begin
            if (!r_stage) begin
                o_op1_addr <= tb.id_addr;
                o_op1_m    <= r_dim_m;
                o_op1_n    <= r_dim_n;
            end else begin
                o_op2_addr <= tb.id_addr;
                o_op2_m    <= r_dim_m;
                o_op2_n    <= r_dim_n;
            end
        end
        // table is idle during execute, so this holds
        if (state == CALC_EXECUTE)
            o_res_addr <= tb.next_addr;
    end

    a_start_in_exec: assert property (@(posedge clk) disable iff (!rst_n)
        o_start_calc |-> state == CALC_EXECUTE);

endmodule

/* hdl/matrix_ctrl_top.sv */
`timescale 1ns/1ns

module matrix_ctrl_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [2:0]                        i_btn,
    input  logic [7:0]                        i_sw,
    input  logic                              i_dims_valid,
    input  logic [matcalc_pkg::DIM_W-1:0]     i_dim_m,
    input  logic [matcalc_pkg::DIM_W-1:0]     i_dim_n,
    input  logic                              i_rx_done,
    input  logic                              i_timeout,
    input  logic                              i_id_valid,
    input  logic [matcalc_pkg::DIM_W-1:0]     i_id_val,
    input  logic                              i_calc_done,
    output logic                              o_en_input,
    output matcalc_pkg::task_t                o_task_mode,
    output logic                              o_addr_ready,
    output logic [matcalc_pkg::ADDR_W-1:0]    o_base_addr,
    output logic                              o_start_calc,
    output matcalc_pkg::op_t                  o_op_code,
    output logic [matcalc_pkg::ADDR_W-1:0]    o_op1_addr,
    output logic [matcalc_pkg::ADDR_W-1:0]    o_op2_addr,
    output logic [matcalc_pkg::DIM_W-1:0]     o_op1_m,
    output logic [matcalc_pkg::DIM_W-1:0]     o_op1_n,
    output logic [matcalc_pkg::DIM_W-1:0]     o_op2_m,
    output logic [matcalc_pkg::DIM_W-1:0]     o_op2_n,
    output logic [matcalc_pkg::ADDR_W-1:0]    o_res_addr,
    output matcalc_pkg::state_t               o_state,
    output logic                              o_logic_error,
    output logic [matcalc_pkg::LED_W-1:0]     o_led,
    output logic [matcalc_pkg::TOTAL_W-1:0]   o_total_count,
    output logic [matcalc_pkg::TYPES_W-1:0]   o_types_count
);

    logic confirm;
    logic retry;
    logic menu;

    table_if tbl_bus ();

    btn_edge u_btn (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_btn     (i_btn),
        .o_confirm (confirm),
        .o_retry   (retry),
        .o_menu    (menu)
    );

    calc_sequencer u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_confirm     (confirm),
        .i_retry       (retry),
        .i_menu        (menu),
        .i_sw          (i_sw),
        .i_dims_valid  (i_dims_valid),
        .i_dim_m       (i_dim_m),
        .i_dim_n       (i_dim_n),
        .i_rx_done     (i_rx_done),
        .i_timeout     (i_timeout),
        .i_id_valid    (i_id_valid),
        .i_id_val      (i_id_val),
        .i_calc_done   (i_calc_done),
        .tb            (tbl_bus.seq),
        .o_en_input    (o_en_input),
        .o_task_mode   (o_task_mode),
        .o_addr_ready  (o_addr_ready),
        .o_base_addr   (o_base_addr),
        .o_start_calc  (o_start_calc),
        .o_op_code     (o_op_code),
        .o_op1_addr    (o_op1_addr),
        .o_op2_addr    (o_op2_addr),
        .o_op1_m       (o_op1_m),
        .o_op1_n       (o_op1_n),
        .o_op2_m       (o_op2_m),
        .o_op2_n       (o_op2_n),
        .o_res_addr    (o_res_addr),
        .o_state       (o_state),
        .o_logic_error (o_logic_error),
        .o_led         (o_led)
    );

    matrix_table u_tbl (
        .clk   (clk),
        .rst_n (rst_n),
        .tb    (tbl_bus.tbl)
    );

    // table occupancy for the board
    assign o_total_count = tbl_bus.total_count;
    assign o_types_count = tbl_bus.types_count;

endmodule

/* sim/clk_gen.sv */
`timescale 1ns/1ns

module clk_gen (
    output logic clk,
    output logic rst_n
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset low for four rising edges
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* sim/tb_matrix_ctrl.sv */
`timescale 1ns/1ns

module tb_matrix_ctrl;
    import matcalc_pkg::*;

    logic                clk;
    logic                rst_n;
    logic [2:0]          i_btn;
    logic [7:0]          i_sw;
    logic                i_dims_valid;
    logic [DIM_W-1:0]    i_dim_m;
    logic [DIM_W-1:0]    i_dim_n;
    logic                i_rx_done;
    logic                i_timeout;
    logic                i_id_valid;
    logic [DIM_W-1:0]    i_id_val;
    logic                i_calc_done;
    logic                o_en_input;
    task_t               o_task_mode;
    logic                o_addr_ready;
    logic [ADDR_W-1:0]   o_base_addr;
    logic                o_start_calc;
    op_t                 o_op_code;
    logic [ADDR_W-1:0]   o_op1_addr;
    logic [ADDR_W-1:0]   o_op2_addr;
    logic [DIM_W-1:0]    o_op1_m;
    logic [DIM_W-1:0]    o_op1_n;
    logic [DIM_W-1:0]    o_op2_m;
    logic [DIM_W-1:0]    o_op2_n;
    logic [ADDR_W-1:0]   o_res_addr;
    state_t              o_state;
    logic                o_logic_error;
    logic [LED_W-1:0]    o_led;
    logic [TOTAL_W-1:0]  o_total_count;
    logic [TYPES_W-1:0]  o_types_count;

    int errors     = 0;
    int wait_limit = 40;

    // table model
    logic [7:0] m_m     [MAX_TYPES];
    logic [7:0] m_n     [MAX_TYPES];
    logic [7:0] m_start [MAX_TYPES];
    bit         m_slot  [MAX_TYPES];
    int         m_cnt   [MAX_TYPES];
    int         m_used  = 0;
    logic [7:0] m_free  = '0;

    // shape pool where 2x3 and 3x2 give a square matmul result
    logic [7:0] pool_m [4] = '{8'd2, 8'd3, 8'd2, 8'd3};
    logic [7:0] pool_n [4] = '{8'd3, 8'd2, 8'd2, 8'd4};

    clk_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    // port names match the tb signals
    matrix_ctrl_top uut (.*);

    // ==================================================
    // reporting
    // ==================================================
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp,
                            input string what);
        if (got !== exp) begin
            errors++;
            stop_run($sformatf("ERROR at %0t ns: %s is %0h, expected %0h",
                               $time, what, got, exp));
        end
    endtask

    function automatic logic [7:0] led_of(input state_t st);
        case (st)
            IDLE:          led_of = LED_IDLE;
            INPUT:         led_of = LED_INPUT;
            WAIT_DECISION: led_of = LED_WAIT;
            ERROR:         led_of = LED_ERROR;
            default:       led_of = LED_CALC;
        endcase
    endfunction

    // ==================================================
    // table model
    // ==================================================
    function automatic int find_entry(input logic [7:0] m, input logic [7:0] n);
        find_entry = -1;
        for (int i = 0; i < m_used; i++) begin
            if (m_m[i] == m && m_n[i] == n)
                find_entry = i;
        end
    endfunction

    function automatic logic [7:0] next_addr_of(input logic [7:0] m, input logic [7:0] n);
        int e;
        e = find_entry(m, n);
        if (e < 0)
            next_addr_of = m_free;
        else
            next_addr_of = m_start[e] + (m_slot[e] ? m * n : 8'd0);
    endfunction

    task automatic store_model(input logic [7:0] m, input logic [7:0] n);
        int e;
        e = find_entry(m, n);
        if (e >= 0) begin
            m_slot[e] = !m_slot[e];
            if (m_cnt[e] < MAX_COPIES)
                m_cnt[e]++;
        end else if (m_used < MAX_TYPES) begin
            m_m[m_used]     = m;
            m_n[m_used]     = n;
            m_start[m_used] = m_free;
            m_slot[m_used]  = 1'b1;
            m_cnt[m_used]   = 1;
            m_free          = m_free + 8'd2 * m * n;
            m_used++;
        end
    endtask

    task automatic check_counts();
        int total;
        total = 0;
        for (int i = 0; i < m_used; i++)
            total += m_cnt[i];
        check_eq(o_types_count, m_used, "types count");
        check_eq(o_total_count, total, "total count");
    endtask

    // ==================================================
    // waits and drivers
    // ==================================================
    task automatic wait_state(input state_t st);
        for (int i = 0; i < wait_limit; i++) begin
            @(negedge clk);
            if (o_state == st) begin
                check_eq(o_led, led_of(st), "led pattern");
                return;
            end
        end
        stop_run($sformatf("timeout at %0t ns: state %s was never reached", $time, st.name()));
    endtask

    // sel 0 address ready, 1 calculator start, 2 logic error
    task automatic wait_flag(input int sel, input string what);
        logic flag;
        for (int i = 0; i < wait_limit; i++) begin
            @(negedge clk);
            case (sel)
                0:       flag = o_addr_ready;
                1:       flag = o_start_calc;
                default: flag = o_logic_error;
            endcase
            if (flag)
                return;
        end
        stop_run($sformatf("timeout at %0t ns: no %s", $time, what));
    endtask

    task automatic press_button(input int b);
        @(posedge clk);
        i_btn[b] <= 1'b1;
        repeat (3) @(posedge clk);
        i_btn[b] <= 1'b0;
    endtask

    task automatic enter_mode(input logic [7:0] sw, input state_t st);
        @(posedge clk);
        i_sw <= sw;
        press_button(0);
        wait_state(st);
    endtask

    task automatic send_dims(input logic [7:0] m, input logic [7:0] n);
        @(posedge clk);
        i_dim_m      <= m;
        i_dim_n      <= n;
        i_dims_valid <= 1'b1;
        @(posedge clk);
        i_dims_valid <= 1'b0;
    endtask

    task automatic send_id(input logic [7:0] id);
        @(posedge clk);
        i_id_val   <= id;
        i_id_valid <= 1'b1;
        @(posedge clk);
        i_id_valid <= 1'b0;
    endtask

    task automatic pulse_timeout();
        @(posedge clk);
        i_timeout <= 1'b1;
        @(posedge clk);
        i_timeout <= 1'b0;
    endtask

    task automatic check_reset();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit)
                stop_run("reset was never released");
        end while (!rst_n);
        check_eq(o_en_input, 0, "input enable after reset");
        check_eq(o_addr_ready, 0, "address ready after reset");
        check_eq(o_start_calc, 0, "start after reset");
        check_eq(o_logic_error, 0, "logic error after reset");
        check_eq(o_led, 0, "led in reset");
        check_eq(o_state, IDLE, "state after reset");
        check_counts();
        // led register loads on the first clock out of reset
        @(negedge clk);
        check_eq(o_led, LED_IDLE, "led after reset");
    endtask

    // ==================================================
    // flows
    // ==================================================
    task automatic store_shape(input logic [7:0] m, input logic [7:0] n);
        logic [7:0] exp_addr;
        exp_addr = next_addr_of(m, n);
        check_eq(o_en_input, 1, "input enable");
        check_eq(o_task_mode, TASK_STORE, "task mode");
        @(posedge clk);
        i_dim_m      <= m;
        i_dim_n      <= n;
        i_dims_valid <= 1'b1;
        wait_flag(0, "address ready");
        check_eq(o_base_addr, exp_addr, "base address");
        store_model(m, n);
        check_counts();
        @(posedge clk);
        i_dims_valid <= 1'b0;
        i_rx_done    <= 1'b1;
        @(posedge clk);
        i_rx_done <= 1'b0;
        wait_state(WAIT_DECISION);
    endtask

    // err 0 clean, 1 unknown shape, 2 index zero, 3 index above count
    task automatic calc_run(input int err);
        int         code;
        int         nops;
        int         e;
        int         e_prev;
        int         id;
        int         lat;
        op_t        exp_op;
        logic [7:0] opm [2];
        logic [7:0] opn [2];
        logic [7:0] opa [2];
        logic [7:0] rm;
        logic [7:0] rn;
        logic [7:0] exp_res;
        code   = $urandom % 8;
        exp_op = (code == 0) ? OP_TRANSPOSE : (code == 3) ? OP_MATMUL : OP_ADD;
        nops   = (exp_op == OP_TRANSPOSE) ? 1 : 2;
        e_prev = 0;
        @(posedge clk);
        i_sw <= {code[2:0], 5'b00010};
        press_button(0);
        wait_state(CALC_GET_DIM);
        check_eq(o_task_mode, TASK_DIMS, "task mode");
        for (int k = 0; k < nops; k++) begin
            if (k == 0 && err == 1) begin
                // 1x1 is never stored
                send_dims(8'd1, 8'd1);
                wait_flag(2, "logic error on unknown shape");
                check_eq(o_state, CALC_GET_DIM, "state after unknown shape");
                check_eq(o_en_input, 1, "input enable after unknown shape");
            end
            e = (k == 1 && exp_op == OP_ADD) ? e_prev : $urandom % m_used;
            send_dims(m_m[e], m_n[e]);
            wait_state(CALC_GET_ID);
            check_eq(o_logic_error, 0, "logic error on known shape");
            check_eq(o_task_mode, TASK_ID, "task mode");
            if (k == 0 && err >= 2) begin
                send_id(err == 2 ? 8'd0 : 8'(m_cnt[e] + 1));
                wait_flag(2, "logic error on bad index");
                check_eq(o_state, CALC_GET_ID, "state after bad index");
                check_eq(o_en_input, 1, "input enable after bad index");
            end
            id     = 1 + $urandom % m_cnt[e];
            opm[k] = m_m[e];
            opn[k] = m_n[e];
            opa[k] = m_start[e] + 8'(id - 1) * m_m[e] * m_n[e];
            e_prev = e;
            send_id(8'(id));
            if (k < nops - 1)
                wait_state(CALC_GET_DIM);
        end
        rm = opm[0];
        rn = opn[0];
        if (exp_op == OP_TRANSPOSE) begin
            rm = opn[0];
            rn = opm[0];
        end else if (exp_op == OP_MATMUL) begin
            rn = opn[1];
        end
        exp_res = next_addr_of(rm, rn);
        wait_flag(1, "calculator start");
        check_eq(o_logic_error, 0, "logic error in execute");
        check_eq(o_op_code, exp_op, "op code");
        check_eq(o_op1_addr, opa[0], "operand 1 address");
        check_eq(o_op1_m, opm[0], "operand 1 m");
        check_eq(o_op1_n, opn[0], "operand 1 n");
        if (nops == 2) begin
            check_eq(o_op2_addr, opa[1], "operand 2 address");
            check_eq(o_op2_m, opm[1], "operand 2 m");
            check_eq(o_op2_n, opn[1], "operand 2 n");
        end
        check_eq(o_res_addr, exp_res, "result address");
        // calculator latency
        lat = 1 + $urandom % 8;
        repeat (lat) begin
            @(negedge clk);
            check_eq(o_start_calc, 1, "start held");
            check_eq(o_res_addr, exp_res, "result address held");
        end
        @(posedge clk);
        i_calc_done <= 1'b1;
        @(posedge clk);
        i_calc_done <= 1'b0;
        store_model(rm, rn);
        wait_state(WAIT_DECISION);
        check_eq(o_start_calc, 0, "start after done");
        check_counts();
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        int pick;
        void'($urandom(32'hf5cf));
        i_btn        <= '0;
        i_sw         <= '0;
        i_dims_valid <= 1'b0;
        i_dim_m      <= '0;
        i_dim_n      <= '0;
        i_rx_done    <= 1'b0;
        i_timeout    <= 1'b0;
        i_id_valid   <= 1'b0;
        i_id_val     <= '0;
        i_calc_done  <= 1'b0;
        check_reset();

        // random stores, then every pool shape once more
        enter_mode(8'h00, INPUT);
        for (int k = 0; k < 14; k++) begin
            pick = (k < 10) ? $urandom % 4 : k - 10;
            store_shape(pool_m[pick], pool_n[pick]);
            press_button(1);
            wait_state(INPUT);
        end
        store_shape(8'd4, 8'd4);
        check_eq(o_types_count, MAX_TYPES, "types count with full table");
        press_button(0);
        wait_state(IDLE);

        enter_mode(8'h02, CALC_SELECT_OP);
        for (int r = 0; r < 12; r++) begin
            calc_run(r % 4);
            press_button(1);
            wait_state(CALC_SELECT_OP);
        end
        press_button(2);
        wait_state(IDLE);

        enter_mode(8'h00, INPUT);
        pulse_timeout();
        wait_state(ERROR);
        press_button(0);
        wait_state(IDLE);

        // menu out of several states
        enter_mode(8'h00, INPUT);
        press_button(2);
        wait_state(IDLE);
        enter_mode(8'h02, CALC_SELECT_OP);
        press_button(0);
        wait_state(CALC_GET_DIM);
        press_button(2);
        wait_state(IDLE);
        enter_mode(8'h00, INPUT);
        store_shape(pool_m[0], pool_n[0]);
        press_button(2);
        wait_state(IDLE);
        enter_mode(8'h00, INPUT);
        pulse_timeout();
        wait_state(ERROR);
        press_button(2);
        wait_state(IDLE);

        if (errors == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_run("checks failed during the run");
        end
    end

endmodule

/* project.f */
common/matcalc_pkg.sv
common/table_if.sv
hdl/btn_edge.sv
mmu/matrix_table.sv
ctrl/calc_sequencer.sv
hdl/matrix_ctrl_top.sv
sim/clk_gen.sv
sim/tb_matrix_ctrl.sv

/* Makefile */
TOOL    = verilator
FLAGS   = --binary --timing --assert -Wno-fatal
TOP     = tb_matrix_ctrl
FLIST   = project.f
OBJ_DIR = obj_dir
LOG     = sim.log
PASS    = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
